// ==== source/segDisplayPkg.sv ====
// shared widths, counts, scan rate and character codes
// for the multiplexed seven-segment text display
package segDisplayPkg;

    // display geometry
    localparam int NumDigits       = 4;                      // positions, 0 is leftmost
    localparam int DigitIndexWidth = $clog2(NumDigits);      // digit select width

    // character and segment codes
    localparam int CharWidth = 7;                            // printable ascii only
    localparam int SegWidth  = 7;                            // abcdefg, 0 lights

    // number converter
    localparam int BinWidth        = 14;                     // host number width
    localparam int BinCountWidth   = $clog2(BinWidth + 1);   // shift counter
    localparam int BcdWidth        = 4 * NumDigits;          // one nibble per digit
    localparam int MaxDisplayValue = 10 ** NumDigits - 1;    // 9999, above shows dashes

    // refresh timing, small so simulation scans quickly
    localparam int ScanDivide     = 16;                      // cycles per lit digit
    localparam int ScanCountWidth = $clog2(ScanDivide);

    // special characters
    localparam logic [CharWidth-1:0] CharSpace = 7'h20;      // blank position
    localparam logic [CharWidth-1:0] CharDash  = 7'h2D;      // overflow marker
    localparam logic [CharWidth-1:0] CharZero  = 7'h30;      // base of decimal digits

    // all segments dark
    localparam logic [SegWidth-1:0] SegBlank = 7'b1111111;

endpackage

// ==== source/asciiToSegments.sv ====
// ascii to seven-segment lookup, abcdefg order, active low
// unsupported codes decode to blank
module asciiToSegments
(
    input  logic [segDisplayPkg::CharWidth-1:0] charCode,   // 7-bit ascii
    output logic [segDisplayPkg::SegWidth-1:0]  segments    // abcdefg, 0 = lit
);
    import segDisplayPkg::*;

    always_comb
    begin
        case (charCode)
            7'd39:  segments = 7'b1011111;   // apostrophe
            7'd45:  segments = 7'b1111110;   // dash, segment g only
            7'd48:  segments = 7'b0000001;   // 0
            7'd49:  segments = 7'b1001111;   // 1
            7'd50:  segments = 7'b0010010;   // 2
            7'd51:  segments = 7'b0000110;   // 3
            7'd52:  segments = 7'b1001100;   // 4
            7'd53:  segments = 7'b0100100;   // 5
            7'd54:  segments = 7'b0100000;   // 6
            7'd55:  segments = 7'b0001111;   // 7
            7'd56:  segments = 7'b0000000;   // 8
            7'd57:  segments = 7'b0000100;   // 9
            7'd61:  segments = 7'b1110110;   // equals, d and g
            // upper case, several shown in a lower case or look-alike form
            7'd65:  segments = 7'b0001000;   // A
            7'd66:  segments = 7'b1100000;   // B shown as b
            7'd67:  segments = 7'b0110001;   // C
            7'd68:  segments = 7'b1000010;   // D shown as d
            7'd69:  segments = 7'b0110000;   // E
            7'd70:  segments = 7'b0111000;   // F
            7'd71:  segments = 7'b0000100;   // G looks like 9
            7'd72:  segments = 7'b1001000;   // H
            7'd73:  segments = 7'b1001111;   // I as right bar
            7'd74:  segments = 7'b1000111;   // J
            7'd75:  segments = SegBlank;     // K not drawable
            7'd76:  segments = 7'b1110001;   // L
            7'd77:  segments = SegBlank;     // M
            7'd78:  segments = SegBlank;     // N
            7'd79:  segments = 7'b0000001;   // O same as zero
            7'd80:  segments = 7'b0011000;   // P
            7'd81:  segments = SegBlank;     // Q
            7'd82:  segments = SegBlank;     // R
            7'd83:  segments = 7'b0100100;   // S same as 5
            7'd84:  segments = SegBlank;     // T
            7'd85:  segments = 7'b1100011;   // U shown as u
            7'd86:  segments = SegBlank;     // V
            7'd87:  segments = SegBlank;     // W
            7'd88:  segments = SegBlank;     // X
            7'd89:  segments = SegBlank;     // Y
            7'd90:  segments = SegBlank;     // Z
            7'd95:  segments = 7'b1110111;   // underscore, segment d
            // lower case
            7'd97:  segments = 7'b0001000;   // a shown as A
            7'd98:  segments = 7'b1100000;   // b
            7'd99:  segments = 7'b1110010;   // c
            7'd100: segments = 7'b1000010;   // d
            7'd101: segments = 7'b0110000;   // e shown as E
            7'd102: segments = 7'b0111000;   // f shown as F
            7'd103: segments = 7'b0000100;   // g looks like 9
            7'd104: segments = 7'b1101000;   // h
            7'd105: segments = 7'b1001111;   // i as right bar
            7'd106: segments = 7'b1000111;   // j shown as J
            7'd107: segments = SegBlank;     // k
            7'd108: segments = 7'b1001111;   // l as right bar
            7'd109: segments = SegBlank;     // m
            7'd110: segments = SegBlank;     // n
            7'd111: segments = 7'b1100010;   // o, lower box
            7'd112: segments = 7'b0011000;   // p shown as P
            7'd113: segments = SegBlank;     // q
            7'd114: segments = SegBlank;     // r
            7'd115: segments = 7'b0100100;   // s same as 5
            7'd116: segments = SegBlank;     // t
            7'd117: segments = 7'b1100011;   // u
            7'd118: segments = SegBlank;     // v
            7'd119: segments = SegBlank;     // w
            7'd120: segments = SegBlank;     // x
            7'd121: segments = SegBlank;     // y
            7'd122: segments = SegBlank;     // z
            default: segments = SegBlank;    // space, controls and other marks
        endcase
    end

endmodule

// ==== source/binaryToDigitText.sv ====
// iterative double-dabble converter, binary to four ascii digits
// blanks leading zeros and shows dashes above the display range
module binaryToDigitText
(
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                numberStrobe,  // one-cycle load request
    input  logic [segDisplayPkg::BinWidth-1:0]  numberValue,
    output logic                                busy,          // high while converting
    output logic                                textStrobe,    // one cycle, text valid
    output logic [segDisplayPkg::NumDigits-1:0][segDisplayPkg::CharWidth-1:0] textDigits
);
    import segDisplayPkg::*;

    logic                                loadAccept;   // strobe taken only when idle
    logic                                finalStep;    // all bits shifted in
    logic [BinCountWidth-1:0]            bitCount;     // bits left to shift
    logic [BinWidth-1:0]                 shiftReg;     // binary still to consume
    logic [BcdWidth-1:0]                 bcd;          // thousands in top nibble
    logic [BcdWidth-1:0]                 bcdAdjusted;  // after add-three
    logic                                overflow;     // value above 9999
    logic                                leadingZero;  // still inside leading zeros
    logic [NumDigits-1:0][CharWidth-1:0] asciiDigits;

    assign loadAccept = numberStrobe && !busy;
    assign finalStep  = busy && (bitCount == '0);

    // add three to any nibble of five or more before it doubles
    always_comb
    begin
        for (int i = 0; i < NumDigits; i++)
        begin
            if (bcd[i*4 +: 4] >= 4'd5)
                bcdAdjusted[i*4 +: 4] = bcd[i*4 +: 4] + 4'd3;
            else
                bcdAdjusted[i*4 +: 4] = bcd[i*4 +: 4];
        end
    end

    // digit 0 is leftmost, so it takes the most significant nibble
    always_comb
    begin
        leadingZero = 1'b1;
        for (int i = 0; i < NumDigits; i++)
        begin
            leadingZero = leadingZero && (bcd[(NumDigits-1-i)*4 +: 4] == 4'd0);
            if (overflow)
                asciiDigits[i] = CharDash;                // out of range
            else if (leadingZero && (i != NumDigits - 1))
                asciiDigits[i] = CharSpace;               // last digit always shown
            else
                asciiDigits[i] = CharZero + CharWidth'(bcd[(NumDigits-1-i)*4 +: 4]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy       <= 1'b0;
            textStrobe <= 1'b0;
            bitCount   <= '0;
        end
        else
        begin
            textStrobe <= 1'b0;                           // pulse only
            if (loadAccept)
            begin
                busy     <= 1'b1;
                bitCount <= BinCountWidth'(BinWidth);
            end
            else if (finalStep)
            begin
                busy       <= 1'b0;                       // falls with the strobe
                textStrobe <= 1'b1;
            end
            else if (busy)
                bitCount <= bitCount - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (loadAccept)
        begin
            shiftReg <= numberValue;
            bcd      <= '0;
            overflow <= numberValue > BinWidth'(MaxDisplayValue);
        end
        else if (busy && !finalStep)
            {bcd, shiftReg} <= {bcdAdjusted[BcdWidth-2:0], shiftReg, 1'b0};  // one bit in
        if (finalStep)
            textDigits <= asciiDigits;
    end

endmodule

// ==== source/textBuffer.sv ====
// four-character text register for the display
// written per character or replaced whole by converted number text
module textBuffer
(
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      charStrobe,  // single character write
    input  logic [segDisplayPkg::DigitIndexWidth-1:0] charIndex,   // 0 is leftmost
    input  logic [segDisplayPkg::CharWidth-1:0]       charCode,
    input  logic                                      textStrobe,  // whole text from converter
    input  logic [segDisplayPkg::NumDigits-1:0][segDisplayPkg::CharWidth-1:0] textDigits,
    output logic [segDisplayPkg::NumDigits-1:0][segDisplayPkg::CharWidth-1:0] bufferChars
);
    import segDisplayPkg::*;

    logic [NumDigits-1:0] charWrite;   // one-hot position enable

    // a character write is dropped when converted text lands in the same cycle
    always_comb
    begin
        for (int i = 0; i < NumDigits; i++)
        begin
            charWrite[i] = charStrobe && !textStrobe
                           && (charIndex == DigitIndexWidth'(i));
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            bufferChars <= {NumDigits{CharSpace}};       // display starts blank
        else
        begin
            for (int i = 0; i < NumDigits; i++)
            begin
                if (textStrobe)
                    bufferChars[i] <= textDigits[i];     // full replacement
                else if (charWrite[i])
                    bufferChars[i] <= charCode;
            end
        end
    end

endmodule

// ==== source/digitScanner.sv ====
// refresh timer and digit select for the multiplexed display
// drives active-low anodes and decoded segments
module digitScanner
(
    input  logic                                clk,
    input  logic                                reset,
    input  logic [segDisplayPkg::NumDigits-1:0][segDisplayPkg::CharWidth-1:0] bufferChars,
    output logic [segDisplayPkg::NumDigits-1:0] anodes,     // one low bit lights a digit
    output logic [segDisplayPkg::SegWidth-1:0]  segments
);
    import segDisplayPkg::*;

    logic                       active;        // set first cycle out of reset
    logic [ScanCountWidth-1:0]  scanCount;     // cycles spent on current digit
    logic [DigitIndexWidth-1:0] digitIndex;    // currently lit position
    logic [CharWidth-1:0]       selectedChar;
    logic [SegWidth-1:0]        decodedSegs;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active     <= 1'b0;
            scanCount  <= '0;
            digitIndex <= '0;
        end
        else if (!active)
            active <= 1'b1;                    // digit 0 starts a full dwell
        else if (scanCount == ScanCountWidth'(ScanDivide - 1))
        begin
            scanCount <= '0;
            if (digitIndex == DigitIndexWidth'(NumDigits - 1))
                digitIndex <= '0;              // wrap to leftmost
            else
                digitIndex <= digitIndex + 1'b1;
        end
        else
            scanCount <= scanCount + 1'b1;
    end

    assign selectedChar = bufferChars[digitIndex];   // combinational, follows buffer

    asciiToSegments u_asciiToSegments
    (
        .charCode (selectedChar),
        .segments (decodedSegs)
    );

    always_comb
    begin
        anodes   = '1;                         // all dark until scanning
        segments = SegBlank;
        if (active)
        begin
            anodes[digitIndex] = 1'b0;
            segments           = decodedSegs;
        end
    end

endmodule

// ==== source/segDisplay.sv ====
// top level of the four-digit text display
// number converter, text buffer and scanner
module segDisplay
(
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      charStrobe,
    input  logic [segDisplayPkg::DigitIndexWidth-1:0] charIndex,
    input  logic [segDisplayPkg::CharWidth-1:0]       charCode,
    input  logic                                      numberStrobe,
    input  logic [segDisplayPkg::BinWidth-1:0]        numberValue,
    output logic                                      busy,
    output logic [segDisplayPkg::NumDigits-1:0]       anodes,
    output logic [segDisplayPkg::SegWidth-1:0]        segments
);
    import segDisplayPkg::*;

    logic                                textStrobe;    // converter to buffer
    logic [NumDigits-1:0][CharWidth-1:0] textDigits;
    logic [NumDigits-1:0][CharWidth-1:0] bufferChars;   // buffer to scanner

    binaryToDigitText u_binaryToDigitText
    (
        .clk          (clk),
        .reset        (reset),
        .numberStrobe (numberStrobe),
        .numberValue  (numberValue),
        .busy         (busy),
        .textStrobe   (textStrobe),
        .textDigits   (textDigits)
    );

    textBuffer u_textBuffer
    (
        .clk         (clk),
        .reset       (reset),
        .charStrobe  (charStrobe),
        .charIndex   (charIndex),
        .charCode    (charCode),
        .textStrobe  (textStrobe),
        .textDigits  (textDigits),
        .bufferChars (bufferChars)
    );

    digitScanner u_digitScanner
    (
        .clk         (clk),
        .reset       (reset),
        .bufferChars (bufferChars),
        .anodes      (anodes),
        .segments    (segments)
    );

endmodule

// ==== testbench/segDisplay_props.sv ====
// concurrent checks on anode scanning and converter busy length
// bound into the display top level
module segDisplay_props
(
    input logic                                clk,
    input logic                                reset,
    input logic                                numberStrobe,
    input logic                                busy,
    input logic [segDisplayPkg::NumDigits-1:0] anodes
);
    timeunit 1ns;
    timeprecision 1ps;
    import segDisplayPkg::*;

    // first cycle out of reset is still dark
    anodesOneCold: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> $onehot(~anodes))
        else $error("anodes %b are not one-cold", anodes);

    for (genvar i = 0; i < NumDigits; i++)
    begin : gDwell
        dwellLength: assert property (@(posedge clk) disable iff (reset)
            $fell(anodes[i]) |-> (!anodes[i]) [*ScanDivide] ##1 anodes[i])
            else $error("digit %0d not lit for %0d cycles", i, ScanDivide);
    end

    // accepted load, busy for shift plus blanking, low at BinWidth+2
    busyLength: assert property (@(posedge clk) disable iff (reset)
        numberStrobe && !busy |=> busy [*BinWidth+1] ##1 !busy)
        else $error("busy length wrong after number load");

endmodule

bind segDisplay segDisplay_props u_segDisplayProps
(
    .clk          (clk),
    .reset        (reset),
    .numberStrobe (numberStrobe),
    .busy         (busy),
    .anodes       (anodes)
);

// ==== testbench/segDisplayTb.sv ====
// testbench for the four-digit text display
// stimulus table, glyph model, decimal formatting, scan sampling and error counts
module segDisplayTb;
    timeunit 1ns;
    timeprecision 1ps;
    import segDisplayPkg::*;

    localparam int RowHold       = 0;                          // keep text, rescan
    localparam int RowChar       = 1;
    localparam int RowNumber     = 2;
    localparam int RowBusyIgnore = 3;                          // second strobe while busy
    localparam int RowCollide    = 4;                          // char write meets textStrobe
    localparam int RandomRows    = 6;
    localparam int IgnoredValue  = 1234;
    localparam int ScanTimeout   = 2 * NumDigits * ScanDivide; // negedges per digit wait
    localparam int BusyTimeout   = BinWidth + 8;

    logic                       clk;
    logic                       reset;
    logic                       charStrobe;
    logic [DigitIndexWidth-1:0] charIndex;
    logic [CharWidth-1:0]       charCode;
    logic                       numberStrobe;
    logic [BinWidth-1:0]        numberValue;
    logic                       busy;
    logic [NumDigits-1:0]       anodes;
    logic [SegWidth-1:0]        segments;

    int    rowKind[$];
    int    rowIndex[$];
    int    rowCode[$];
    int    rowValue[$];
    string rowExpect[$];                                       // text as it should look
    int    errorCount;
    int    timeoutCount;
    int    checkCount;
    bit    timedOut;                                           // stops the row loop

    segDisplay u_segDisplay
    (
        .clk          (clk),
        .reset        (reset),
        .charStrobe   (charStrobe),
        .charIndex    (charIndex),
        .charCode     (charCode),
        .numberStrobe (numberStrobe),
        .numberValue  (numberValue),
        .busy         (busy),
        .anodes       (anodes),
        .segments     (segments)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;                                 // 8 ns period
    end

    // abcdefg, active low, substitutions as in the reference table
    function automatic logic [SegWidth-1:0] glyph(input logic [CharWidth-1:0] code);
        case ({1'b0, code})
            "'":                 return 7'b1011111;
            "-":                 return 7'b1111110;
            "0", "O":            return 7'b0000001;
            "1", "I", "i", "l":  return 7'b1001111;
            "2":                 return 7'b0010010;
            "3":                 return 7'b0000110;
            "4":                 return 7'b1001100;
            "5", "S", "s":       return 7'b0100100;
            "6":                 return 7'b0100000;
            "7":                 return 7'b0001111;
            "8":                 return 7'b0000000;
            "9", "G", "g":       return 7'b0000100;
            "=":                 return 7'b1110110;
            "A", "a":            return 7'b0001000;
            "B", "b":            return 7'b1100000;
            "C":                 return 7'b0110001;
            "c":                 return 7'b1110010;
            "D", "d":            return 7'b1000010;
            "E", "e":            return 7'b0110000;
            "F", "f":            return 7'b0111000;
            "H":                 return 7'b1001000;
            "h":                 return 7'b1101000;
            "J", "j":            return 7'b1000111;
            "L":                 return 7'b1110001;
            "o":                 return 7'b1100010;
            "P", "p":            return 7'b0011000;
            "U", "u":            return 7'b1100011;
            "_":                 return 7'b1110111;
            default:             return 7'b1111111;            // not drawable
        endcase
    endfunction

    // right aligned, leading zeros blank, dashes past four digits
    function automatic string formatNumber(input int value);
        string text;
        int    rest;
        text = "    ";
        rest = value;
        if (value > (10 ** NumDigits) - 1)
            text = "----";
        else
            for (int pos = NumDigits - 1; pos >= 0; pos--)
            begin
                if (pos == NumDigits - 1 || rest != 0)
                    text[pos] = byte'(8'd48 + rest % 10);
                rest = rest / 10;
            end
        return text;
    endfunction

    task automatic addRow(input int kind, input int index, input int code, input int value,
                          input string expectText);
        rowKind.push_back(kind);
        rowIndex.push_back(index);
        rowCode.push_back(code);
        rowValue.push_back(value);
        rowExpect.push_back(expectText);
    endtask

    task automatic buildTable();
        int value;
        addRow(RowHold,   0, 0,     0, "    ");             // blank after reset
        addRow(RowChar,   0, "1",   0, "1   ");
        addRow(RowChar,   1, "-",   0, "1-  ");
        addRow(RowChar,   2, "A",   0, "1-A ");
        addRow(RowChar,   3, "b",   0, "1-Ab");
        addRow(RowChar,   3, "K",   0, "1-AK");             // K has no glyph
        addRow(RowChar,   1, 7'h07, 0, "1 AK");             // bell code shows blank
        addRow(RowChar,   0, "_",   0, "_ AK");
        addRow(RowChar,   1, "'",   0, "_'AK");
        addRow(RowChar,   2, "=",   0, "_'=K");
        addRow(RowChar,   3, "h",   0, "_'=h");
        addRow(RowChar,   0, "9",   0, "9'=h");
        addRow(RowChar,   1, "S",   0, "9S=h");
        addRow(RowChar,   2, "o",   0, "9Soh");
        addRow(RowHold,   0, 0,     0, "9Soh");
        addRow(RowNumber, 0, 0,     0, "   0");
        addRow(RowNumber, 0, 0,     7, "   7");
        addRow(RowNumber, 0, 0,    42, "  42");
        addRow(RowNumber, 0, 0,  9999, "9999");
        addRow(RowNumber, 0, 0, 10000, "----");
        addRow(RowNumber, 0, 0, 16383, "----");             // largest input
        addRow(RowNumber, 0, 0,   305, " 305");             // inner zero kept
        addRow(RowBusyIgnore, 0, 0, 58, "  58");
        addRow(RowCollide, 0, "8", 612, " 612");            // drawable, so a lost write shows
        addRow(RowChar,   0, "c",   0, "c612");
        for (int i = 0; i < RandomRows; i++)
        begin
            value = int'($urandom_range(2 ** BinWidth - 1));
            addRow(RowNumber, 0, 0, value, formatNumber(value));
        end
    endtask

    // drive tasks start and end 1 ns after a rising edge
    task automatic writeChar(input int index, input int code);
        charStrobe = 1'b1;
        charIndex  = DigitIndexWidth'(index);
        charCode   = CharWidth'(code);
        @(posedge clk);
        #1;
        charStrobe = 1'b0;
    endtask

    task automatic loadNumber(input int value);
        numberStrobe = 1'b1;
        numberValue  = BinWidth'(value);
        @(posedge clk);
        #1;
        numberStrobe = 1'b0;
    endtask

    task automatic waitBusyLow();
        int cycles;
        cycles = 0;
        while (busy && cycles < BusyTimeout)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (busy)
        begin
            $display("busy did not fall within %0d cycles of a number load", BusyTimeout);
            timeoutCount++;
            timedOut = 1'b1;
        end
    endtask

    // sample on falling edges, away from the drive point
    task automatic waitForDigit(input int digit);
        int                   cycles;
        logic [NumDigits-1:0] wanted;
        logic [NumDigits-1:0] previous;
        cycles   = 0;
        wanted   = ~(NumDigits'(1) << digit);                  // one-cold
        previous = ~(NumDigits'(1) << ((digit + NumDigits - 1) % NumDigits));
        @(negedge clk);
        while (anodes !== wanted && cycles < ScanTimeout)
        begin
            if ($countones(~anodes) != 1)
            begin
                errorCount++;
                $display("FAIL %0t: anodes %b do not light exactly one digit", $time, anodes);
            end
            else if (digit != 0 && anodes !== previous)
            begin
                errorCount++;
                $display("FAIL %0t: anodes %b lit out of order before digit %0d",
                         $time, anodes, digit);
            end
            @(negedge clk);
            cycles++;
        end
        if (anodes !== wanted)
        begin
            $display("digit %0d was never lit by the scanner", digit);
            timeoutCount++;
            timedOut = 1'b1;
        end
    endtask

    task automatic checkScan(input int row);
        string               expectText;
        byte                 ch;
        logic [SegWidth-1:0] wanted;
        expectText = rowExpect[row];
        for (int d = 0; d < NumDigits; d++)
        begin
            waitForDigit(d);
            if (timedOut)
                return;
            ch     = expectText[d];
            wanted = glyph(ch[CharWidth-1:0]);
            checkCount++;
            if (segments !== wanted)
            begin
                errorCount++;
                $display("FAIL %0t: row %0d digit %0d segments %b, expected %b for \"%s\"",
                         $time, row, d, segments, wanted, expectText);
            end
        end
        @(posedge clk);
        #1;                                                    // back to the drive point
    endtask

    task automatic applyRow(input int row);
        case (rowKind[row])
            RowChar:
                writeChar(rowIndex[row], rowCode[row]);
            RowNumber, RowBusyIgnore, RowCollide:
            begin
                loadNumber(rowValue[row]);
                checkCount++;
                if (busy !== 1'b1)
                begin
                    errorCount++;
                    $display("FAIL %0t: row %0d busy %b after number load", $time, row, busy);
                end
                if (rowKind[row] == RowBusyIgnore)
                    loadNumber(IgnoredValue);                  // must be dropped
                waitBusyLow();
                if (rowKind[row] == RowCollide && !timedOut)
                    writeChar(rowIndex[row], rowCode[row]);    // same edge as textStrobe
            end
            default:
            begin
                repeat (ScanDivide) @(posedge clk);
                #1;
            end
        endcase
    endtask

    initial
    begin
        void'($urandom(32'hd045dbd4));
        reset        = 1'b1;
        charStrobe   = 1'b0;
        charIndex    = '0;
        charCode     = '0;
        numberStrobe = 1'b0;
        numberValue  = '0;
        errorCount   = 0;
        timeoutCount = 0;
        checkCount   = 0;
        timedOut     = 1'b0;
        buildTable();
        repeat (4) @(posedge clk);
        @(negedge clk);
        checkCount++;
        if (anodes !== '1 || busy !== 1'b0)
        begin
            errorCount++;
            $display("FAIL %0t: in reset anodes %b busy %b", $time, anodes, busy);
        end
        repeat (4) @(posedge clk);                             // 8 cycles of reset
        #1;
        reset = 1'b0;
        for (int row = 0; row < rowKind.size(); row++)
        begin
            applyRow(row);
            if (!timedOut)
            begin
                repeat (2) @(posedge clk);                     // buffer settles
                checkScan(row);
            end
            if (timedOut)
                break;
        end
        $display("checks %0d, value errors %0d, timeouts %0d",
                 checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== tb.f ====
source/segDisplayPkg.sv
source/asciiToSegments.sv
source/binaryToDigitText.sv
source/textBuffer.sv
source/digitScanner.sv
source/segDisplay.sv
testbench/segDisplay_props.sv
testbench/segDisplayTb.sv

// ==== Bender.yml ====
package:
  name: seg_display

sources:
  - files:
      - source/segDisplayPkg.sv
      - source/asciiToSegments.sv
      - source/binaryToDigitText.sv
      - source/textBuffer.sv
      - source/digitScanner.sv
      - source/segDisplay.sv
  - target: test
    files:
      - testbench/segDisplay_props.sv
      - testbench/segDisplayTb.sv
